// ==== rtl/ex_defs.svh ====
// Width macros for the execute stage; include wherever a bus width is needed
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Integer data width, also the width of the jump target
`define EX_XLEN 32

// Register file address, one bit wider than RV32 to reach the extra bank
`define EX_RADDR_W 6

// ALU opcode width, sized for the full 16-entry opcode enum
`define EX_ALU_OP_W 4

`endif

// ==== rtl/ex_pkg.sv ====
// Shared types of the execute stage; ports name them with ex_pkg:: scoping
`include "ex_defs.svh"

package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and states
  ////////////////////////////////////////////////////////////////////////////

  // ALU operators, compare group last
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA,
    SLT, SLTU, EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  // Multiplier operators
  typedef enum logic {
    MUL,
    MULH
  } mult_op_e;

  // Multiplier sequencer for the two-cycle high word
  typedef enum logic {
    IDLE,
    STEP
  } mult_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Request and write-port bundles
  ////////////////////////////////////////////////////////////////////////////

  // ALU request from ID, operand_c carries the jump target
  typedef struct packed {
    alu_op_e                operator;
    logic [`EX_XLEN-1:0]    operand_a;
    logic [`EX_XLEN-1:0]    operand_b;
    logic [`EX_XLEN-1:0]    operand_c;
  } alu_req_t;

  // Multiplier request, signed_mode[0] for a and signed_mode[1] for b
  typedef struct packed {
    mult_op_e               operator;
    logic [`EX_XLEN-1:0]    operand_a;
    logic [`EX_XLEN-1:0]    operand_b;
    logic [1:0]             signed_mode;
  } mult_req_t;

  // Register file write port
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } rf_wr_t;

endpackage

// ==== rtl/ex_alu.sv ====
// Combinational integer ALU with branch comparator; instantiated once in ex_stage
`include "ex_defs.svh"

module ex_alu (
  input  ex_pkg::alu_req_t     req_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_result_o
);

  import ex_pkg::*;

  logic [`EX_XLEN-1:0] op_a;
  logic [`EX_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                lt_s;
  logic                lt_u;
  logic                eq;
  logic                cmp_flag;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  // Only the low five bits of b matter for a 32-bit shift
  assign shamt = op_b[4:0];

  // Shared comparator, reused by SLT and every branch test
  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;
  assign eq   = op_a == op_b;

  ////////////////////////////////////////////////////////////////////////////
  // Compare flag
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cmp_flag = 1'b0;
    case (req_i.operator)
      SLT:     cmp_flag = lt_s;
      SLTU:    cmp_flag = lt_u;
      EQ:      cmp_flag = eq;
      NE:      cmp_flag = ~eq;
      LT:      cmp_flag = lt_s;
      GE:      cmp_flag = ~lt_s;
      LTU:     cmp_flag = lt_u;
      GEU:     cmp_flag = ~lt_u;
      // Arithmetic, logic and shifts leave the flag low
      default: cmp_flag = 1'b0;
    endcase
  end

  // Branch decision, low for non-compare operators
  assign cmp_result_o = cmp_flag;

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (req_i.operator)
      ADD:     result_o = op_a + op_b;
      SUB:     result_o = op_a - op_b;
      AND:     result_o = op_a & op_b;
      OR:      result_o = op_a | op_b;
      XOR:     result_o = op_a ^ op_b;
      SLL:     result_o = op_a << shamt;
      SRL:     result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign of a
      SRA:     result_o = $signed(op_a) >>> shamt;
      // Compare group returns the flag zero-extended
      default: result_o = {{(`EX_XLEN-1){1'b0}}, cmp_flag};
    endcase
  end

endmodule

// ==== rtl/ex_mult.sv ====
// Integer multiplier with a one-cycle MUL and a two-cycle MULH; used by ex_stage
`include "ex_defs.svh"

module ex_mult (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,
  input  ex_pkg::mult_req_t    req_i,
  input  logic                 ex_ready_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 multicycle_o,
  output logic                 ready_o
);

  import ex_pkg::*;

  mult_state_e state_q;
  mult_state_e state_d;

  // Operands widened by one bit, sign or zero per signed_mode
  logic signed [`EX_XLEN:0]     op_a_ext;
  logic signed [`EX_XLEN:0]     op_b_ext;
  logic signed [2*`EX_XLEN+1:0] prod_full;
  logic [2*`EX_XLEN-1:0]        prod_q;
  logic                         start_mulh;

  assign op_a_ext  = $signed({req_i.signed_mode[0] & req_i.operand_a[`EX_XLEN-1],
                              req_i.operand_a});
  assign op_b_ext  = $signed({req_i.signed_mode[1] & req_i.operand_b[`EX_XLEN-1],
                              req_i.operand_b});
  assign prod_full = op_a_ext * op_b_ext;

  // A MULH only starts from IDLE
  assign start_mulh = enable_i & (req_i.operator == MULH) & (state_q == IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // High-word sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start_mulh) state_d = STEP;
      // Hold the high word until EX can move on
      STEP: if (ex_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Product register, only loaded when a MULH starts
  always_ff @(posedge clk) begin
    if (start_mulh) begin
      prod_q <= prod_full[2*`EX_XLEN-1:0];
    end
  end

  // First MULH cycle stalls EX
  assign multicycle_o = start_mulh;
  assign ready_o      = ~start_mulh;

  // STEP presents the stored high word, otherwise the low product
  assign result_o = (state_q == STEP) ? prod_q[2*`EX_XLEN-1:`EX_XLEN]
                                      : prod_full[`EX_XLEN-1:0];

endmodule

// ==== rtl/ex_writeback.sv ====
// Forward-port mux, EX/WB register and stall logic; instantiated by ex_stage
`include "ex_defs.svh"

module ex_writeback (
  input  logic                    clk,
  input  logic                    rst_n,

  // Unit enables from ID
  input  logic                    alu_en_i,
  input  logic                    mult_en_i,
  input  logic                    csr_access_i,
  input  logic                    lsu_en_i,

  // Result sources
  input  logic [`EX_XLEN-1:0]     alu_result_i,
  input  logic [`EX_XLEN-1:0]     mult_result_i,
  input  logic [`EX_XLEN-1:0]     csr_rdata_i,

  input  logic                    regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                    regfile_we_i,
  input  logic [`EX_RADDR_W-1:0]  regfile_waddr_i,

  input  logic [`EX_XLEN-1:0]     lsu_rdata_i,
  input  logic                    mult_ready_i,
  input  logic                    lsu_ready_ex_i,
  input  logic                    branch_in_ex_i,
  input  logic                    wb_ready_i,

  output ex_pkg::rf_wr_t          regfile_alu_fw_o,
  output ex_pkg::rf_wr_t          regfile_wb_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  logic                   we_lsu_q;
  logic [`EX_RADDR_W-1:0] waddr_lsu_q;
  logic                   units_ready;

  ////////////////////////////////////////////////////////////////////////////
  // ALU write port, CSR over multiplier over ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    regfile_alu_fw_o.we    = regfile_alu_we_i;
    regfile_alu_fw_o.waddr = regfile_alu_waddr_i;
    regfile_alu_fw_o.wdata = alu_result_i;
    if (csr_access_i) begin
      regfile_alu_fw_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_fw_o.wdata = mult_result_i;
    end
  end

  // Stall control
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  // Branches finish in EX, so they never wait for WB
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // EX/WB register for the load/store port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_lsu_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      // Nothing new from EX, drain the slot
      we_lsu_q <= 1'b0;
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  assign regfile_wb_o.we    = we_lsu_q;
  assign regfile_wb_o.waddr = waddr_lsu_q;
  // Load data arrives straight from the LSU
  assign regfile_wb_o.wdata = lsu_rdata_i;

endmodule

// ==== rtl/ex_stage.sv ====
// Execute stage top level; connects ALU, multiplier and write-back to the core
`include "ex_defs.svh"

module ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,

  // ALU and multiplier requests from ID
  input  ex_pkg::alu_req_t        alu_req_i,
  input  logic                    alu_en_i,
  input  ex_pkg::mult_req_t       mult_req_i,
  input  logic                    mult_en_i,

  // CSR and load/store side
  input  logic                    csr_access_i,
  input  logic [`EX_XLEN-1:0]     csr_rdata_i,
  input  logic                    lsu_en_i,
  input  logic [`EX_XLEN-1:0]     lsu_rdata_i,
  input  logic                    lsu_ready_ex_i,

  input  logic                    branch_in_ex_i,
  input  logic                    regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                    regfile_we_i,
  input  logic [`EX_RADDR_W-1:0]  regfile_waddr_i,
  input  logic                    wb_ready_i,

  output ex_pkg::rf_wr_t          regfile_alu_fw_o,
  output ex_pkg::rf_wr_t          regfile_wb_o,
  output logic [`EX_XLEN-1:0]     jump_target_o,
  output logic                    branch_decision_o,
  output logic                    mult_multicycle_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;
  logic                ex_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Multiplier holds its high word until the stage is ready
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback u_wb (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .wb_ready_i          (wb_ready_i),
    .regfile_alu_fw_o    (regfile_alu_fw_o),
    .regfile_wb_o        (regfile_wb_o),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid_o)
  );

  assign ex_ready_o = ex_ready;

  // Branch outputs to IF, target computed in ID
  assign jump_target_o     = alu_req_i.operand_c;
  assign branch_decision_o = alu_cmp_result;

endmodule

// ==== sim/ex_checker.sv ====
// Scoreboard for the execute stage; samples DUT outputs mid-cycle against table values
`include "ex_defs.svh"

module ex_checker (
  input  logic                 clk,
  input  logic                 chk_en_i,
  input  logic                 done_i,
  input  logic [7:0]           test_id_i,
  input  ex_pkg::rf_wr_t       exp_fw_i,
  input  logic                 exp_fw_data_i,
  input  logic                 exp_branch_i,
  input  logic [`EX_XLEN-1:0]  exp_jump_i,
  input  logic                 exp_multicycle_i,
  input  logic                 exp_ready_i,
  input  logic                 exp_valid_i,
  input  ex_pkg::rf_wr_t       exp_wb_i,
  input  ex_pkg::rf_wr_t       fw_i,
  input  ex_pkg::rf_wr_t       wb_i,
  input  logic [`EX_XLEN-1:0]  jump_i,
  input  logic                 branch_i,
  input  logic                 multicycle_i,
  input  logic                 ready_i,
  input  logic                 valid_i,
  output int                   err_count_o,
  output logic                 summary_done_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int         errors = 0;
  int         checks = 0;
  int         test_errors = 0;
  int         test_checks = 0;
  int         tests_done = 0;
  logic [7:0] cur_test = '0;
  logic       summary_done = 1'b0;

  assign err_count_o    = errors;
  assign summary_done_o = summary_done;

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    test_checks++;
    // Case inequality so X on a port counts as wrong
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Fail at %0d ns: test %0d, %s is %h, expected %h",
               $time, cur_test, what, got, exp);
    end
  endtask

  task automatic close_test();
    if (cur_test != 8'd0) begin
      $display("Test %0d finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
      tests_done++;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // Negative edge sits between input drive and the next rising edge
  always @(negedge clk) begin
    if (chk_en_i) begin
      if (test_id_i != cur_test) begin
        close_test();
        cur_test = test_id_i;
      end
      compare("fw we", 32'(fw_i.we), 32'(exp_fw_i.we));
      compare("fw waddr", 32'(fw_i.waddr), 32'(exp_fw_i.waddr));
      if (exp_fw_data_i) begin
        compare("fw wdata", fw_i.wdata, exp_fw_i.wdata);
      end
      compare("branch decision", 32'(branch_i), 32'(exp_branch_i));
      compare("jump target", jump_i, exp_jump_i);
      compare("mult multicycle", 32'(multicycle_i), 32'(exp_multicycle_i));
      compare("ex_ready", 32'(ready_i), 32'(exp_ready_i));
      compare("ex_valid", 32'(valid_i), 32'(exp_valid_i));
      compare("wb we", 32'(wb_i.we), 32'(exp_wb_i.we));
      // Address only meaningful with a pending write
      if (exp_wb_i.we) begin
        compare("wb waddr", 32'(wb_i.waddr), 32'(exp_wb_i.waddr));
      end
      compare("wb wdata", wb_i.wdata, exp_wb_i.wdata);
    end
    if (done_i && !summary_done) begin
      close_test();
      cur_test = '0;
      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      summary_done = 1'b1;
    end
  end

endmodule

// ==== sim/ex_stage_sva.sv ====
// Concurrent checks on stall and write-back outputs; bound into every ex_stage instance
module ex_stage_sva (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           ex_valid_o,
  input  logic           ex_ready_o,
  input  logic           wb_ready_i,
  input  logic           mult_multicycle_o,
  input  logic           branch_in_ex_i,
  input  ex_pkg::rf_wr_t regfile_wb_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Valid work only leaves EX when WB can take it
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> wb_ready_i)
    else begin
      fail_count++;
      $error("ex_valid_o high while wb_ready_i is low");
    end

  // First MULH cycle stalls the stage unless a branch overrides
  mulh_stalls: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_multicycle_o && !branch_in_ex_i) |-> !ex_ready_o)
    else begin
      fail_count++;
      $error("ex_ready_o high during the first MULH cycle");
    end

  // EX/WB slot empty when reset is released
  wb_clear_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !regfile_wb_o.we)
    else begin
      fail_count++;
      $error("regfile_wb_o.we set right after reset");
    end

endmodule

bind ex_stage ex_stage_sva u_sva (
  .clk               (clk),
  .rst_n             (rst_n),
  .ex_valid_o        (ex_valid_o),
  .ex_ready_o        (ex_ready_o),
  .wb_ready_i        (wb_ready_i),
  .mult_multicycle_o (mult_multicycle_o),
  .branch_in_ex_i    (branch_in_ex_i),
  .regfile_wb_o      (regfile_wb_o)
);

// ==== sim/tb_ex_stage.sv ====
// Testbench top for the execute stage; builds a stimulus table and runs it on the DUT
`include "ex_defs.svh"

module tb_ex_stage;

  timeunit 1ns;
  timeprecision 100ps;

  import ex_pkg::*;

  // One table row, all DUT inputs for one cycle
  typedef struct packed {
    logic [7:0]             test_id;
    alu_req_t               alu_req;
    logic                   alu_en;
    mult_req_t              mult_req;
    logic                   mult_en;
    logic                   csr_access;
    logic [`EX_XLEN-1:0]    csr_rdata;
    logic                   lsu_en;
    logic [`EX_XLEN-1:0]    lsu_rdata;
    logic                   lsu_ready_ex;
    logic                   branch_in_ex;
    logic                   alu_we;
    logic [`EX_RADDR_W-1:0] alu_waddr;
    logic                   rf_we;
    logic [`EX_RADDR_W-1:0] rf_waddr;
    logic                   wb_ready;
  } stim_t;

  // Expected outputs for the same cycle
  typedef struct packed {
    rf_wr_t              fw;
    logic                chk_fw_data;
    logic                branch;
    logic [`EX_XLEN-1:0] jump;
    logic                multicycle;
    logic                ready;
    logic                valid;
    rf_wr_t              wb;
  } expect_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  alu_req_t               alu_req;
  logic                   alu_en;
  mult_req_t              mult_req;
  logic                   mult_en;
  logic                   csr_access;
  logic [`EX_XLEN-1:0]    csr_rdata;
  logic                   lsu_en;
  logic [`EX_XLEN-1:0]    lsu_rdata;
  logic                   lsu_ready_ex;
  logic                   branch_in_ex;
  logic                   alu_we;
  logic [`EX_RADDR_W-1:0] alu_waddr;
  logic                   rf_we;
  logic [`EX_RADDR_W-1:0] rf_waddr;
  logic                   wb_ready;

  rf_wr_t                 fw_port;
  rf_wr_t                 wb_port;
  logic [`EX_XLEN-1:0]    jump_target;
  logic                   branch_decision;
  logic                   mult_multicycle;
  logic                   ex_ready;
  logic                   ex_valid;

  stim_t                  stim_q[$];
  expect_t                exp_q[$];
  integer                 seed = 88;

  // Reference state carried from row to row while the table is built
  mult_state_e            m_state = IDLE;
  logic [`EX_XLEN-1:0]    m_hi = '0;
  logic                   m_wb_we = 1'b0;
  logic [`EX_RADDR_W-1:0] m_wb_waddr = '0;

  int                     cycle_count = 0;
  int                     cycle_limit = 1000;
  logic                   chk_en = 1'b0;
  logic                   done = 1'b0;
  logic [7:0]             cur_test = '0;
  expect_t                cur_exp = '0;
  int                     err_count;
  logic                   summary_done;

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [`EX_XLEN-1:0] next_random();
    return $random(seed);
  endfunction

  // Signed order by flipping the sign bits and comparing unsigned
  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  endfunction

  function automatic logic branch_taken(input alu_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
    case (op)
      SLT, LT:   return signed_less(a, b);
      SLTU, LTU: return a < b;
      EQ:        return a == b;
      NE:        return a != b;
      GE:        return !signed_less(a, b);
      GEU:       return !(a < b);
      default:   return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_value(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [63:0] ext;
    logic [4:0]  sh;
    sh  = b[4:0];
    ext = {{32{a[31]}}, a};
    case (op)
      ADD:     return a + b;
      // Two's complement of b added
      SUB:     return a + ~b + 32'd1;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA: begin
        ext = ext >> sh;
        return ext[31:0];
      end
      default: return {31'b0, branch_taken(op, a, b)};
    endcase
  endfunction

  // 64-bit product, each operand widened per its signed_mode bit
  function automatic logic [63:0] full_product(input logic [31:0] a, input logic [31:0] b,
                                               input logic [1:0] mode);
    logic [63:0] ax;
    logic [63:0] bx;
    ax = mode[0] ? {{32{a[31]}}, a} : {32'b0, a};
    bx = mode[1] ? {{32{b[31]}}, b} : {32'b0, b};
    return ax * bx;
  endfunction

  // Idle row with random data on every bus
  function automatic stim_t idle_stim(input logic [7:0] tid);
    stim_t               s;
    logic [`EX_XLEN-1:0] w;
    s                    = '0;
    s.test_id            = tid;
    s.alu_req.operator   = ADD;
    s.alu_req.operand_a  = next_random();
    s.alu_req.operand_b  = next_random();
    s.alu_req.operand_c  = next_random();
    s.mult_req.operator  = MUL;
    s.mult_req.operand_a = next_random();
    s.mult_req.operand_b = next_random();
    s.csr_rdata          = next_random();
    s.lsu_rdata          = next_random();
    s.lsu_ready_ex       = 1'b1;
    s.wb_ready           = 1'b1;
    w                    = next_random();
    s.alu_waddr          = w[`EX_RADDR_W-1:0];
    w                    = next_random();
    s.rf_waddr           = w[`EX_RADDR_W-1:0];
    return s;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_entry(input stim_t s);
    expect_t     e;
    logic        start;
    logic        units;
    logic [63:0] prod;
    prod  = full_product(s.mult_req.operand_a, s.mult_req.operand_b,
                         s.mult_req.signed_mode);
    start = s.mult_en && (s.mult_req.operator == MULH) && (m_state == IDLE);
    units = !start && s.lsu_ready_ex && s.wb_ready;
    e = '0;
    e.ready      = units || s.branch_in_ex;
    e.valid      = (s.alu_en || s.mult_en || s.csr_access || s.lsu_en) && units;
    e.multicycle = start;
    e.branch     = branch_taken(s.alu_req.operator, s.alu_req.operand_a,
                                s.alu_req.operand_b);
    e.jump        = s.alu_req.operand_c;
    e.fw.we       = s.alu_we;
    e.fw.waddr    = s.alu_waddr;
    e.chk_fw_data = 1'b1;
    // Forward data priority CSR, multiplier, ALU
    if (s.csr_access) begin
      e.fw.wdata = s.csr_rdata;
    end else if (s.mult_en) begin
      if (m_state == STEP) begin
        e.fw.wdata = m_hi;
      end else if (start) begin
        e.chk_fw_data = 1'b0;
      end else begin
        e.fw.wdata = prod[31:0];
      end
    end else begin
      e.fw.wdata = alu_value(s.alu_req.operator, s.alu_req.operand_a,
                             s.alu_req.operand_b);
    end
    e.wb.we    = m_wb_we;
    e.wb.waddr = m_wb_waddr;
    e.wb.wdata = s.lsu_rdata;
    // Advance the reference state past this clock edge
    if (start) begin
      m_hi    = prod[63:32];
      m_state = STEP;
    end else if (m_state == STEP && e.ready) begin
      m_state = IDLE;
    end
    if (e.valid) begin
      m_wb_we = s.rf_we;
      if (s.rf_we) begin
        m_wb_waddr = s.rf_waddr;
      end
    end else if (s.wb_ready) begin
      m_wb_we = 1'b0;
    end
    stim_q.push_back(s);
    exp_q.push_back(e);
  endtask

  task automatic build_table();
    stim_t s;
    // Test 1, every ALU operator
    for (int i = 0; i < 16; i++) begin
      s = idle_stim(8'd1);
      s.alu_req.operator = alu_op_e'(i);
      s.alu_en = 1'b1;
      s.alu_we = 1'b1;
      add_entry(s);
    end
    // Test 2, branch compares with equal and random operands
    for (int i = int'(EQ); i <= int'(GEU); i++) begin
      s = idle_stim(8'd2);
      s.alu_req.operator  = alu_op_e'(i);
      s.alu_en            = 1'b1;
      s.alu_req.operand_b = s.alu_req.operand_a;
      add_entry(s);
      s = idle_stim(8'd2);
      s.alu_req.operator = alu_op_e'(i);
      s.alu_en           = 1'b1;
      add_entry(s);
    end
    // Test 3, MUL then MULH held for two cycles per signed_mode
    s = idle_stim(8'd3);
    s.mult_en              = 1'b1;
    s.mult_req.signed_mode = 2'b11;
    s.alu_we               = 1'b1;
    add_entry(s);
    for (int m = 0; m < 4; m++) begin
      s = idle_stim(8'd3);
      s.mult_en                = 1'b1;
      s.mult_req.operator      = MULH;
      s.mult_req.signed_mode   = m[1:0];
      // Both operands negative, so every signed_mode gives its own high word
      s.mult_req.operand_a[31] = 1'b1;
      s.mult_req.operand_b[31] = 1'b1;
      s.alu_we                 = 1'b1;
      add_entry(s);
      add_entry(s);
    end
    // Test 4, forward-port priority
    s = idle_stim(8'd4);
    s.csr_access = 1'b1;
    s.mult_en    = 1'b1;
    s.alu_en     = 1'b1;
    s.alu_we     = 1'b1;
    add_entry(s);
    s = idle_stim(8'd4);
    s.mult_en = 1'b1;
    s.alu_en  = 1'b1;
    add_entry(s);
    // Test 5, load write then drain
    s = idle_stim(8'd5);
    s.lsu_en = 1'b1;
    s.rf_we  = 1'b1;
    add_entry(s);
    add_entry(idle_stim(8'd5));
    add_entry(idle_stim(8'd5));
    // Test 6, WB back-pressure with and without a branch
    s = idle_stim(8'd6);
    s.lsu_en = 1'b1;
    s.rf_we  = 1'b1;
    add_entry(s);
    s = idle_stim(8'd6);
    s.lsu_en   = 1'b1;
    s.rf_we    = 1'b1;
    s.wb_ready = 1'b0;
    add_entry(s);
    s.branch_in_ex = 1'b1;
    add_entry(s);
    s = idle_stim(8'd6);
    s.wb_ready = 1'b0;
    add_entry(s);
    add_entry(idle_stim(8'd6));
    add_entry(idle_stim(8'd6));
  endtask

  task automatic drive(input stim_t s);
    alu_req      = s.alu_req;
    alu_en       = s.alu_en;
    mult_req     = s.mult_req;
    mult_en      = s.mult_en;
    csr_access   = s.csr_access;
    csr_rdata    = s.csr_rdata;
    lsu_en       = s.lsu_en;
    lsu_rdata    = s.lsu_rdata;
    lsu_ready_ex = s.lsu_ready_ex;
    branch_in_ex = s.branch_in_ex;
    alu_we       = s.alu_we;
    alu_waddr    = s.alu_waddr;
    rf_we        = s.rf_we;
    rf_waddr     = s.rf_waddr;
    wb_ready     = s.wb_ready;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////////////////////////////////////////

  ex_stage uut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .mult_req_i          (mult_req),
    .mult_en_i           (mult_en),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .branch_in_ex_i      (branch_in_ex),
    .regfile_alu_we_i    (alu_we),
    .regfile_alu_waddr_i (alu_waddr),
    .regfile_we_i        (rf_we),
    .regfile_waddr_i     (rf_waddr),
    .wb_ready_i          (wb_ready),
    .regfile_alu_fw_o    (fw_port),
    .regfile_wb_o        (wb_port),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  ex_checker u_chk (
    .clk              (clk),
    .chk_en_i         (chk_en),
    .done_i           (done),
    .test_id_i        (cur_test),
    .exp_fw_i         (cur_exp.fw),
    .exp_fw_data_i    (cur_exp.chk_fw_data),
    .exp_branch_i     (cur_exp.branch),
    .exp_jump_i       (cur_exp.jump),
    .exp_multicycle_i (cur_exp.multicycle),
    .exp_ready_i      (cur_exp.ready),
    .exp_valid_i      (cur_exp.valid),
    .exp_wb_i         (cur_exp.wb),
    .fw_i             (fw_port),
    .wb_i             (wb_port),
    .jump_i           (jump_target),
    .branch_i         (branch_decision),
    .multicycle_i     (mult_multicycle),
    .ready_i          (ex_ready),
    .valid_i          (ex_valid),
    .err_count_o      (err_count),
    .summary_done_o   (summary_done)
  );

  // Run limit scales with the table length
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    build_table();
    cycle_limit = stim_q.size() * 4 + 20;
    drive(idle_stim(8'd0));
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    // One row per cycle, driven just after the rising edge
    foreach (stim_q[k]) begin
      @(posedge clk);
      #1;
      drive(stim_q[k]);
      cur_exp  = exp_q[k];
      cur_test = stim_q[k].test_id;
      chk_en   = 1'b1;
    end
    @(posedge clk);
    #1;
    chk_en = 1'b0;
    done   = 1'b1;
    wait (summary_done);
    if (err_count == 0 && uut.u_sva.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("Assertion failures: %0d", uut.u_sva.fail_count);
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
sim/ex_checker.sv
sim/ex_stage_sva.sv
sim/tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_ex_stage -Mdir obj_dir -f tb.f; then
  echo "Build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_ex_stage +verilator+error+limit+1000 > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi

cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
